// ==== dv/executeCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module executeCoreTb;

  typedef struct packed {
    logic [2:0]            testId;
    isaPkg::opCodeT        op;
    datapathPkg::regAddrT  src;
    datapathPkg::regAddrT  dst;
    datapathPkg::dataWordT immVal;
    datapathPkg::dataWordT inVal;
    datapathPkg::flagsT    expFlags;
    datapathPkg::dataWordT expOut;
    logic                  checkAddr;
    datapathPkg::dataWordT expAddr;
    logic                  expRead;
    logic                  expWrite;
    datapathPkg::dataWordT expWriteData;
    logic                  expTaken;
    datapathPkg::dataWordT expTarget;
  } stimRowT;

  logic                  clk;
  logic                  rstN;
  isaPkg::opCodeT        opCode;
  datapathPkg::regAddrT  rSrc;
  datapathPkg::regAddrT  rDst;
  datapathPkg::dataWordT imm;
  datapathPkg::dataWordT inPort;
  datapathPkg::dataWordT memReadData;
  datapathPkg::dataWordT memAddr;
  datapathPkg::dataWordT memWriteData;
  logic                  memRead;
  logic                  memWrite;
  datapathPkg::dataWordT outPort;
  datapathPkg::flagsT    flags;
  logic                  branchTaken;
  datapathPkg::dataWordT branchTarget;

  datapathPkg::dataWordT mem [0:65535];
  stimRowT               stimTable [$];
  int                    seed = 33146;
  int                    cycleCount = 0;
  int                    cycleLimit = 0;
  int                    errorCount = 0;
  int                    testErrors = 0;
  int                    testsPassed = 0;
  int                    testsFailed = 0;
  logic [2:0]            rowTest;

  // Reference model state, advanced while the table is built
  datapathPkg::dataWordT modelRegs [`REG_COUNT];
  datapathPkg::flagsT    modelFlags;
  datapathPkg::dataWordT modelSp;
  datapathPkg::dataWordT modelOut;
  datapathPkg::dataWordT modelMem [datapathPkg::dataWordT];

  executeCore u_executeCore (
    .clk          (clk),
    .rstN         (rstN),
    .opCode       (opCode),
    .rSrc         (rSrc),
    .rDst         (rDst),
    .imm          (imm),
    .inPort       (inPort),
    .memReadData  (memReadData),
    .memAddr      (memAddr),
    .memWriteData (memWriteData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .outPort      (outPort),
    .flags        (flags),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Data memory answers in the same cycle
  assign memReadData = mem[memAddr];

  always @(posedge clk) begin
    if (memWrite) begin
      mem[memAddr] <= memWriteData;
    end
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic datapathPkg::dataWordT fillWord(input datapathPkg::dataWordT addr);
    return {addr[7:0], addr[15:8]} ^ 16'h5AA5;
  endfunction

  function automatic datapathPkg::dataWordT randomWord();
    return 16'($random(seed));
  endfunction

  function automatic datapathPkg::dataWordT memoryLookup(input datapathPkg::dataWordT addr);
    if (modelMem.exists(addr)) begin
      return modelMem[addr];
    end
    return fillWord(addr);
  endfunction

  // Returns {carry, result}
  function automatic logic [16:0] aluReference(input isaPkg::opCodeT op,
                                               input datapathPkg::dataWordT a,
                                               input datapathPkg::dataWordT b);
    logic [16:0] wide;
    int          n;
    wide = '0;
    n = int'(b[3:0]);
    case (op)
      isaPkg::opAdd: begin
        wide[15:0] = a + b;
        wide[16]   = (int'(a) + int'(b) > 65535);
      end
      isaPkg::opSub: begin
        wide[15:0] = a - b;
        wide[16]   = (a < b);
      end
      isaPkg::opAnd: wide[15:0] = a & b;
      isaPkg::opOr:  wide[15:0] = a | b;
      isaPkg::opNot: wide[15:0] = ~b;
      isaPkg::opInc: begin
        wide[15:0] = b + 16'd1;
        wide[16]   = (b == 16'hFFFF);
      end
      isaPkg::opDec: begin
        wide[15:0] = b - 16'd1;
        wide[16]   = (b == 16'h0000);
      end
      isaPkg::opShl: begin
        wide[15:0] = a << n;
        if (n > 0) begin
          wide[16] = a[16 - n];
        end
      end
      isaPkg::opShr: begin
        wide[15:0] = a >> n;
        if (n > 0) begin
          wide[16] = a[n - 1];
        end
      end
      default: wide = '0;
    endcase
    return wide;
  endfunction

  task automatic addRow(input isaPkg::opCodeT op, input datapathPkg::regAddrT src,
                        input datapathPkg::regAddrT dst, input datapathPkg::dataWordT immVal,
                        input datapathPkg::dataWordT inVal);
    stimRowT               row;
    datapathPkg::dataWordT a;
    datapathPkg::dataWordT d;
    datapathPkg::dataWordT v;
    logic [16:0]           res;
    row = '0;
    a = modelRegs[src];
    d = modelRegs[dst];
    row.testId    = rowTest;
    row.op        = op;
    row.src       = src;
    row.dst       = dst;
    row.immVal    = immVal;
    row.inVal     = inVal;
    // State seen while this row is presented
    row.expFlags  = modelFlags;
    row.expOut    = modelOut;
    row.expTarget = d;
    case (op)
      isaPkg::opLdm: modelRegs[dst] = immVal;
      isaPkg::opMov: modelRegs[dst] = a;
      isaPkg::opIn:  modelRegs[dst] = inVal;
      isaPkg::opOut: begin
        modelOut       = a;
        modelRegs[dst] = a;
      end
      isaPkg::opSetc: modelFlags[2] = 1'b1;
      isaPkg::opClrc: modelFlags[2] = 1'b0;
      isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
      isaPkg::opNot, isaPkg::opInc, isaPkg::opDec: begin
        res = aluReference(op, a, d);
        modelRegs[dst] = res[15:0];
        modelFlags     = {res[16], res[15], res[15:0] == 16'h0};
      end
      // Shift amount from the immediate
      isaPkg::opShl, isaPkg::opShr: begin
        res = aluReference(op, a, immVal);
        modelRegs[dst] = res[15:0];
        modelFlags     = {res[16], res[15], res[15:0] == 16'h0};
      end
      isaPkg::opPush: begin
        row.checkAddr    = 1'b1;
        row.expAddr      = modelSp;
        row.expWrite     = 1'b1;
        row.expWriteData = a;
        modelMem[modelSp] = a;
        modelSp = modelSp - 16'd1;
      end
      isaPkg::opPop, isaPkg::opRtiB: begin
        v = memoryLookup(modelSp + 16'd1);
        row.checkAddr  = 1'b1;
        row.expAddr    = modelSp + 16'd1;
        row.expRead    = 1'b1;
        modelRegs[dst] = v;
        modelSp        = modelSp + 16'd1;
        if (op == isaPkg::opRtiB) begin
          row.expTaken = 1'b1;
          modelFlags   = v[2:0];
        end
      end
      isaPkg::opStd: begin
        row.checkAddr    = 1'b1;
        row.expAddr      = d;
        row.expWrite     = 1'b1;
        row.expWriteData = a;
        modelMem[d] = a;
      end
      isaPkg::opLdd: begin
        row.checkAddr  = 1'b1;
        row.expAddr    = a;
        row.expRead    = 1'b1;
        modelRegs[dst] = memoryLookup(a);
      end
      isaPkg::opJz:  row.expTaken = modelFlags[0];
      isaPkg::opJn:  row.expTaken = modelFlags[1];
      isaPkg::opJc:  row.expTaken = modelFlags[2];
      isaPkg::opJmp: row.expTaken = 1'b1;
      default: begin
      end
    endcase
    stimTable.push_back(row);
  endtask

  task automatic buildTable();
    isaPkg::opCodeT        aluOps [7];
    datapathPkg::dataWordT addr;
    aluOps = '{isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
               isaPkg::opNot, isaPkg::opInc, isaPkg::opDec};
    for (int r = 0; r < `REG_COUNT; r++) begin
      modelRegs[r] = '0;
    end
    modelFlags = '0;
    modelSp    = `SP_RESET;
    modelOut   = '0;

    rowTest = 3'd1;
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 5, 5, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);

    rowTest = 3'd2;
    addRow(isaPkg::opLdm, 0, 1, randomWord(), 16'h0);
    addRow(isaPkg::opLdm, 0, 2, randomWord(), 16'h0);
    // r3 gets a fresh copy of r2 before each operation
    foreach (aluOps[k]) begin
      addRow(isaPkg::opMov, 2, 3, 16'h0, 16'h0);
      addRow(aluOps[k], 1, 3, 16'h0, 16'h0);
      addRow(isaPkg::opOut, 3, 3, 16'h0, 16'h0);
    end
    addRow(isaPkg::opShl, 1, 3, randomWord() & 16'h000F, 16'h0);
    addRow(isaPkg::opOut, 3, 3, 16'h0, 16'h0);
    addRow(isaPkg::opShr, 1, 3, randomWord() & 16'h000F, 16'h0);
    addRow(isaPkg::opOut, 3, 3, 16'h0, 16'h0);
    addRow(isaPkg::opMov, 1, 3, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 3, 3, 16'h0, 16'h0);
    // Carry out of INC, borrow of DEC
    addRow(isaPkg::opLdm, 0, 4, 16'hFFFF, 16'h0);
    addRow(isaPkg::opInc, 0, 4, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 4, 4, 16'h0, 16'h0);
    addRow(isaPkg::opLdm, 0, 4, 16'h0000, 16'h0);
    addRow(isaPkg::opDec, 0, 4, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 4, 4, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);

    rowTest = 3'd3;
    addRow(isaPkg::opLdm, 0, 5, randomWord(), 16'h0);
    addRow(isaPkg::opLdm, 0, 6, randomWord(), 16'h0);
    addRow(isaPkg::opClrc, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opSetc, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opClrc, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opSetc, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opAnd, 5, 6, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 6, 6, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);

    rowTest = 3'd4;
    for (int r = 1; r <= 3; r++) begin
      addRow(isaPkg::opLdm, 0, 3'(r), randomWord(), 16'h0);
    end
    for (int r = 1; r <= 3; r++) begin
      addRow(isaPkg::opPush, 3'(r), 0, 16'h0, 16'h0);
    end
    for (int r = 4; r <= 6; r++) begin
      addRow(isaPkg::opPop, 0, 3'(r), 16'h0, 16'h0);
    end
    for (int r = 4; r <= 6; r++) begin
      addRow(isaPkg::opOut, 3'(r), 3'(r), 16'h0, 16'h0);
    end
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);

    rowTest = 3'd5;
    addr = randomWord();
    addr[15:8] = 8'h40;
    addRow(isaPkg::opLdm, 0, 1, addr, 16'h0);
    addRow(isaPkg::opLdm, 0, 2, randomWord(), 16'h0);
    addRow(isaPkg::opStd, 2, 1, 16'h0, 16'h0);
    addRow(isaPkg::opLdd, 1, 3, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 3, 3, 16'h0, 16'h0);
    // Untouched location returns the fill pattern
    addr = randomWord();
    addr[15:8] = 8'h60;
    addRow(isaPkg::opLdm, 0, 5, addr, 16'h0);
    addRow(isaPkg::opLdd, 5, 6, 16'h0, 16'h0);
    addRow(isaPkg::opOut, 6, 6, 16'h0, 16'h0);
    addRow(isaPkg::opIn, 0, 4, 16'h0, randomWord());
    addRow(isaPkg::opOut, 4, 4, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);

    rowTest = 3'd6;
    addRow(isaPkg::opLdm, 0, 7, randomWord(), 16'h0);
    addRow(isaPkg::opLdm, 0, 1, 16'h0000, 16'h0);
    addRow(isaPkg::opLdm, 0, 2, 16'h0000, 16'h0);
    addRow(isaPkg::opAdd, 1, 2, 16'h0, 16'h0);
    addRow(isaPkg::opJz, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJn, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJc, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJmp, 0, 7, 16'h0, 16'h0);
    // Zero result with carry out
    addRow(isaPkg::opLdm, 0, 1, 16'h8000, 16'h0);
    addRow(isaPkg::opLdm, 0, 2, 16'h8000, 16'h0);
    addRow(isaPkg::opAdd, 1, 2, 16'h0, 16'h0);
    addRow(isaPkg::opJc, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJn, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJz, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opLdm, 0, 1, 16'h0001, 16'h0);
    addRow(isaPkg::opLdm, 0, 2, 16'h0002, 16'h0);
    addRow(isaPkg::opSub, 1, 2, 16'h0, 16'h0);
    addRow(isaPkg::opJn, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJz, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJc, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJmp, 0, 2, 16'h0, 16'h0);
    // Saved flags {C, N, Z} = 101 restored by the second RTI step
    addRow(isaPkg::opLdm, 0, 3, 16'h0005, 16'h0);
    addRow(isaPkg::opPush, 3, 0, 16'h0, 16'h0);
    addRow(isaPkg::opRtiB, 0, 4, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);
    addRow(isaPkg::opJz, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJn, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opJc, 0, 7, 16'h0, 16'h0);
    addRow(isaPkg::opNop, 0, 0, 16'h0, 16'h0);
  endtask

  task automatic compareValue(input string what, input int step,
                              input datapathPkg::dataWordT got,
                              input datapathPkg::dataWordT exp);
    assert (got === exp) else begin
      errorCount++;
      testErrors++;
      $display("FAILED at %0t: step %0d, %s is %h, expected %h", $time, step, what, got, exp);
    end
  endtask

  function automatic string testName(input int id);
    case (id)
      1:       return "reset state";
      2:       return "ALU operations";
      3:       return "carry set and clear";
      4:       return "stack push and pop";
      5:       return "memory and input port";
      default: return "branches and flag restore";
    endcase
  endfunction

  task automatic reportTest(input int id);
    if (testErrors == 0) begin
      testsPassed++;
      $display("Test %0d %s: ok", id, testName(id));
    end else begin
      testsFailed++;
      $display("Test %0d %s: %0d errors", id, testName(id), testErrors);
    end
    testErrors = 0;
  endtask

  initial begin
    stimRowT row;
    int      current;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = fillWord(16'(a));
    end
    rstN   = 1'b0;
    opCode = isaPkg::opNop;
    rSrc   = '0;
    rDst   = '0;
    imm    = '0;
    inPort = '0;
    buildTable();
    cycleLimit = stimTable.size() * 4 + 64;
    current = 1;

    for (int k = 0; k < 16; k++) begin
      @(posedge clk);
      #2;
      compareValue("memRead during reset", k, {15'h0, memRead}, 16'h0);
      compareValue("memWrite during reset", k, {15'h0, memWrite}, 16'h0);
      compareValue("branchTaken during reset", k, {15'h0, branchTaken}, 16'h0);
    end
    rstN = 1'b1;

    foreach (stimTable[i]) begin
      row = stimTable[i];
      if (int'(row.testId) != current) begin
        reportTest(current);
        current = int'(row.testId);
      end
      @(posedge clk);
      #2;
      opCode = row.op;
      rSrc   = row.src;
      rDst   = row.dst;
      imm    = row.immVal;
      inPort = row.inVal;
      @(negedge clk);
      compareValue("flags", i, {13'h0, flags}, {13'h0, row.expFlags});
      compareValue("outPort", i, outPort, row.expOut);
      compareValue("memRead", i, {15'h0, memRead}, {15'h0, row.expRead});
      compareValue("memWrite", i, {15'h0, memWrite}, {15'h0, row.expWrite});
      compareValue("branchTaken", i, {15'h0, branchTaken}, {15'h0, row.expTaken});
      compareValue("branchTarget", i, branchTarget, row.expTarget);
      if (row.checkAddr) begin
        compareValue("memAddr", i, memAddr, row.expAddr);
      end
      if (row.expWrite) begin
        compareValue("memWriteData", i, memWriteData, row.expWriteData);
      end
    end
    reportTest(current);

    $display("Tests: %0d passed, %0d failed, %0d check errors",
             testsPassed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/isaPkg.sv
hw/datapathPkg.sv
hw/controlUnit.sv
hw/alu.sv
hw/registerFile.sv
hw/flagUnit.sv
hw/memoryInterface.sv
hw/executeCore.sv
dv/executeCoreTb.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module alu (
  input  wire isaPkg::aluOpT         aluOp,
  input  wire datapathPkg::dataWordT a,
  input  wire datapathPkg::dataWordT b,
  output datapathPkg::dataWordT      result,
  output logic                       carry
);

  localparam int shiftBits = $clog2(`DATA_WIDTH);

  logic [shiftBits-1:0] shiftAmount;

  assign shiftAmount = b[shiftBits-1:0];

  always_comb begin
    result = '0;
    carry  = 1'b0;
    case (aluOp)
      isaPkg::aluAdd: {carry, result} = {1'b0, a} + {1'b0, b};
      // Borrow shows up in the extra top bit
      isaPkg::aluSub: {carry, result} = {1'b0, a} - {1'b0, b};
      isaPkg::aluAnd: result = a & b;
      isaPkg::aluOr:  result = a | b;
      isaPkg::aluShl: {carry, result} = {1'b0, a} << shiftAmount;
      // Last bit out of the low end lands in carry
      isaPkg::aluShr: {result, carry} = {a, 1'b0} >> shiftAmount;
      isaPkg::aluNot: result = ~b;
      isaPkg::aluPassB: result = b;
      isaPkg::aluInc: {carry, result} = {1'b0, b} + 1'b1;
      isaPkg::aluDec: {carry, result} = {1'b0, b} - 1'b1;
      isaPkg::aluPassA: result = a;
      default: begin
        result = '0;
        carry  = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  wire isaPkg::opCodeT opCode,
  output isaPkg::aluOpT       ALUControl,
  output isaPkg::spOpT        SPOperation,
  output isaPkg::carryOpT     CarryFlag,
  output logic                RegWrite,
  output logic                MemRead,
  output logic                MemWrite,
  output logic                MemOrReg,
  output logic                UpdateStatus,
  output logic                ImmOrReg,
  output logic                SPOrALUres,
  output logic                DestOrPrivate,
  output logic                BranchFlag,
  output logic                PCControl,
  output logic                privateRegWrite,
  output logic                PortRead,
  output logic                PortWrite,
  output isaPkg::branchCondT  BranchCond
);

  // ALU operation per opcode
  always_comb begin
    case (opCode)
      isaPkg::opNot: ALUControl = isaPkg::aluNot;
      isaPkg::opInc: ALUControl = isaPkg::aluInc;
      isaPkg::opDec: ALUControl = isaPkg::aluDec;
      isaPkg::opSub: ALUControl = isaPkg::aluSub;
      isaPkg::opAnd: ALUControl = isaPkg::aluAnd;
      isaPkg::opOr:  ALUControl = isaPkg::aluOr;
      isaPkg::opShl: ALUControl = isaPkg::aluShl;
      isaPkg::opShr: ALUControl = isaPkg::aluShr;
      isaPkg::opLdm, isaPkg::opStd: ALUControl = isaPkg::aluPassB;
      isaPkg::opOut, isaPkg::opIn, isaPkg::opMov, isaPkg::opLdd: ALUControl = isaPkg::aluPassA;
      default: ALUControl = isaPkg::aluAdd;
    endcase
  end

  always_comb begin
    SPOperation     = isaPkg::spHold;
    CarryFlag       = isaPkg::carryFromAlu;
    BranchCond      = isaPkg::condZero;
    RegWrite        = 1'b0;
    MemRead         = 1'b0;
    MemWrite        = 1'b0;
    MemOrReg        = 1'b0;
    UpdateStatus    = 1'b0;
    ImmOrReg        = 1'b0;
    SPOrALUres      = 1'b0;
    DestOrPrivate   = 1'b0;
    BranchFlag      = 1'b0;
    PCControl       = 1'b0;
    privateRegWrite = 1'b0;
    PortRead        = 1'b0;
    PortWrite       = 1'b0;
    case (opCode)
      isaPkg::opSetc, isaPkg::opClrc: begin
        UpdateStatus = 1'b1;
        CarryFlag    = (opCode == isaPkg::opSetc) ? isaPkg::carrySet : isaPkg::carryClear;
      end
      isaPkg::opNot, isaPkg::opInc, isaPkg::opDec, isaPkg::opAdd,
      isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr: begin
        RegWrite     = 1'b1;
        MemOrReg     = 1'b1;
        UpdateStatus = 1'b1;
        ImmOrReg     = 1'b1;
      end
      isaPkg::opOut, isaPkg::opIn, isaPkg::opMov: begin
        RegWrite  = 1'b1;
        MemOrReg  = 1'b1;
        ImmOrReg  = 1'b1;
        PortWrite = (opCode == isaPkg::opOut);
        PortRead  = (opCode == isaPkg::opIn);
      end
      // Shift amount comes from the immediate
      isaPkg::opShl, isaPkg::opShr: begin
        RegWrite     = 1'b1;
        MemOrReg     = 1'b1;
        UpdateStatus = 1'b1;
      end
      isaPkg::opLdm: begin
        RegWrite = 1'b1;
        MemOrReg = 1'b1;
      end
      isaPkg::opLdd: begin
        RegWrite   = 1'b1;
        MemRead    = 1'b1;
        SPOrALUres = 1'b1;
      end
      isaPkg::opStd: begin
        MemWrite   = 1'b1;
        ImmOrReg   = 1'b1;
        SPOrALUres = 1'b1;
      end
      isaPkg::opPush, isaPkg::opCall, isaPkg::opInt, isaPkg::opIntB: begin
        SPOperation     = isaPkg::spPush;
        MemWrite        = 1'b1;
        privateRegWrite = (opCode == isaPkg::opCall) || (opCode == isaPkg::opInt);
      end
      isaPkg::opCallB: begin
        SPOperation = isaPkg::spPush;
        MemWrite    = 1'b1;
        BranchFlag  = 1'b1;
        BranchCond  = isaPkg::condAlways;
      end
      isaPkg::opPop, isaPkg::opRet, isaPkg::opRti: begin
        SPOperation = isaPkg::spPop;
        RegWrite    = 1'b1;
        MemRead     = 1'b1;
      end
      // Second steps of RET and RTI jump unconditionally
      isaPkg::opRetB, isaPkg::opRtiB: begin
        SPOperation   = isaPkg::spPop;
        RegWrite      = 1'b1;
        MemRead       = 1'b1;
        DestOrPrivate = 1'b1;
        BranchFlag    = 1'b1;
        BranchCond    = isaPkg::condAlways;
        if (opCode == isaPkg::opRtiB) begin
          UpdateStatus = 1'b1;
          CarryFlag    = isaPkg::carryRestore;
        end
      end
      isaPkg::opJz, isaPkg::opJn, isaPkg::opJc, isaPkg::opJmp: begin
        BranchFlag = 1'b1;
        BranchCond = isaPkg::branchCondT'(opCode[1:0]);
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Register and memory word width
`define DATA_WIDTH 16

`define REG_COUNT 8

// Stack grows down from the top of the low page
`define SP_RESET 16'h00FF

`endif

// ==== hw/datapathPkg.sv ====
`default_nettype none

`include "core_config.svh"

package datapathPkg;

  typedef logic [`DATA_WIDTH-1:0] dataWordT;

  typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;

  // Ordered {C, N, Z}
  typedef logic [2:0] flagsT;

endpackage

`default_nettype wire

// ==== hw/executeCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeCore (
  input  wire                        clk,
  input  wire                        rstN,
  input  wire isaPkg::opCodeT        opCode,
  input  wire datapathPkg::regAddrT  rSrc,
  input  wire datapathPkg::regAddrT  rDst,
  input  wire datapathPkg::dataWordT imm,
  input  wire datapathPkg::dataWordT inPort,
  input  wire datapathPkg::dataWordT memReadData,
  output datapathPkg::dataWordT      memAddr,
  output datapathPkg::dataWordT      memWriteData,
  output logic                       memRead,
  output logic                       memWrite,
  output datapathPkg::dataWordT      outPort,
  output datapathPkg::flagsT         flags,
  output logic                       branchTaken,
  output datapathPkg::dataWordT      branchTarget
);

  isaPkg::aluOpT         aluOp;
  isaPkg::spOpT          spOperation;
  isaPkg::carryOpT       carryOp;
  isaPkg::branchCondT    branchCond;
  logic                  regWrite;
  logic                  memOrReg;
  logic                  updateStatus;
  logic                  immOrReg;
  logic                  spOrAluRes;
  logic                  branchFlag;
  logic                  portRead;
  logic                  portWrite;
  logic                  aluCarry;
  datapathPkg::dataWordT srcValue;
  datapathPkg::dataWordT dstValue;
  datapathPkg::dataWordT operandB;
  datapathPkg::dataWordT aluResult;
  datapathPkg::dataWordT writebackData;

  // Private-register path has no consumer in this slice
  controlUnit u_controlUnit (
    .opCode          (opCode),
    .ALUControl      (aluOp),
    .SPOperation     (spOperation),
    .CarryFlag       (carryOp),
    .RegWrite        (regWrite),
    .MemRead         (memRead),
    .MemWrite        (memWrite),
    .MemOrReg        (memOrReg),
    .UpdateStatus    (updateStatus),
    .ImmOrReg        (immOrReg),
    .SPOrALUres      (spOrAluRes),
    .DestOrPrivate   (),
    .BranchFlag      (branchFlag),
    .PCControl       (),
    .privateRegWrite (),
    .PortRead        (portRead),
    .PortWrite       (portWrite),
    .BranchCond      (branchCond)
  );

  registerFile u_registerFile (
    .clk         (clk),
    .rstN        (rstN),
    .readAddrA   (rSrc),
    .readAddrB   (rDst),
    .writeEnable (regWrite),
    .writeAddr   (rDst),
    .writeData   (writebackData),
    .readDataA   (srcValue),
    .readDataB   (dstValue)
  );

  assign operandB     = immOrReg ? dstValue : imm;
  assign branchTarget = dstValue;

  alu u_alu (
    .aluOp  (aluOp),
    .a      (srcValue),
    .b      (operandB),
    .result (aluResult),
    .carry  (aluCarry)
  );

  flagUnit u_flagUnit (
    .clk          (clk),
    .rstN         (rstN),
    .updateStatus (updateStatus),
    .carryOp      (carryOp),
    .aluResult    (aluResult),
    .aluCarry     (aluCarry),
    .restoreValue (memReadData[2:0]),
    .branchFlag   (branchFlag),
    .branchCond   (branchCond),
    .flags        (flags),
    .branchTaken  (branchTaken)
  );

  memoryInterface u_memoryInterface (
    .clk           (clk),
    .rstN          (rstN),
    .spOperation   (spOperation),
    .spOrAluRes    (spOrAluRes),
    .memOrReg      (memOrReg),
    .portRead      (portRead),
    .portWrite     (portWrite),
    .aluResult     (aluResult),
    .srcValue      (srcValue),
    .memReadData   (memReadData),
    .inPort        (inPort),
    .memAddr       (memAddr),
    .memWriteData  (memWriteData),
    .writebackData (writebackData),
    .outPort       (outPort)
  );

endmodule

`default_nettype wire

// ==== hw/flagUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flagUnit (
  input  wire                         clk,
  input  wire                         rstN,
  input  wire                         updateStatus,
  input  wire isaPkg::carryOpT        carryOp,
  input  wire datapathPkg::dataWordT  aluResult,
  input  wire                         aluCarry,
  input  wire datapathPkg::flagsT     restoreValue,
  input  wire                         branchFlag,
  input  wire isaPkg::branchCondT     branchCond,
  output datapathPkg::flagsT          flags,
  output logic                        branchTaken
);

  logic condMet;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (updateStatus) begin
      case (carryOp)
        isaPkg::carryFromAlu: flags <= {aluCarry, aluResult[$bits(aluResult)-1], aluResult == '0};
        isaPkg::carryClear:   flags[2] <= 1'b0;
        isaPkg::carrySet:     flags[2] <= 1'b1;
        isaPkg::carryRestore: flags <= restoreValue;
        default:              flags <= flags;
      endcase
    end
  end

  // Condition checked against flags from before this instruction
  always_comb begin
    case (branchCond)
      isaPkg::condZero:  condMet = flags[0];
      isaPkg::condNeg:   condMet = flags[1];
      isaPkg::condCarry: condMet = flags[2];
      default:           condMet = 1'b1;
    endcase
  end

  assign branchTaken = branchFlag & condMet;

endmodule

`default_nettype wire

// ==== hw/isaPkg.sv ====
`default_nettype none

package isaPkg;

  // Opcodes in encoding order, 5'b00000 upward
  typedef enum logic [4:0] {
    opNop,
    opSetc,
    opClrc,
    opNot,
    opInc,
    opDec,
    opOut,
    opIn,
    opMov,
    opAdd,
    opSub,
    opAnd,
    opOr,
    opShl,
    opShr,
    opPush,
    opPop,
    opLdm,
    opLdd,
    opStd,
    opJz,
    opJn,
    opJc,
    opJmp,
    opCall,
    opCallB,
    opRet,
    opRetB,
    opRti,
    opRtiB,
    opInt,
    opIntB
  } opCodeT;

  typedef enum logic [3:0] {
    aluAdd   = 4'b0000,
    aluSub   = 4'b0001,
    aluAnd   = 4'b0010,
    aluOr    = 4'b0011,
    aluShl   = 4'b0100,
    aluShr   = 4'b0101,
    aluNot   = 4'b0110,
    aluPassB = 4'b0111,
    aluInc   = 4'b1000,
    aluDec   = 4'b1001,
    aluPassA = 4'b1010
  } aluOpT;

  typedef enum logic [1:0] {
    spHold = 2'b00,
    spPush = 2'b01,
    spPop  = 2'b10
  } spOpT;

  typedef enum logic [1:0] {
    carryFromAlu = 2'b00,
    carryClear   = 2'b01,
    carryRestore = 2'b10,
    carrySet     = 2'b11
  } carryOpT;

  typedef enum logic [1:0] {
    condZero   = 2'b00,
    condNeg    = 2'b01,
    condCarry  = 2'b10,
    condAlways = 2'b11
  } branchCondT;

endpackage

`default_nettype wire

// ==== hw/memoryInterface.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module memoryInterface (
  input  wire                        clk,
  input  wire                        rstN,
  input  wire isaPkg::spOpT          spOperation,
  input  wire                        spOrAluRes,
  input  wire                        memOrReg,
  input  wire                        portRead,
  input  wire                        portWrite,
  input  wire datapathPkg::dataWordT aluResult,
  input  wire datapathPkg::dataWordT srcValue,
  input  wire datapathPkg::dataWordT memReadData,
  input  wire datapathPkg::dataWordT inPort,
  output datapathPkg::dataWordT      memAddr,
  output datapathPkg::dataWordT      memWriteData,
  output datapathPkg::dataWordT      writebackData,
  output datapathPkg::dataWordT      outPort
);

  datapathPkg::dataWordT sp;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      sp <= `SP_RESET;
    end else if (spOperation == isaPkg::spPush) begin
      sp <= sp - 1'b1;
    end else if (spOperation == isaPkg::spPop) begin
      sp <= sp + 1'b1;
    end
  end

  // Push writes at SP, pop reads the slot above it
  always_comb begin
    if (spOrAluRes) begin
      memAddr = aluResult;
    end else if (spOperation == isaPkg::spPop) begin
      memAddr = sp + 1'b1;
    end else begin
      memAddr = sp;
    end
  end

  assign memWriteData  = srcValue;
  assign writebackData = portRead ? inPort : (memOrReg ? aluResult : memReadData);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outPort <= '0;
    end else if (portWrite) begin
      outPort <= aluResult;
    end
  end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module registerFile (
  input  wire                        clk,
  input  wire                        rstN,
  input  wire datapathPkg::regAddrT  readAddrA,
  input  wire datapathPkg::regAddrT  readAddrB,
  input  wire                        writeEnable,
  input  wire datapathPkg::regAddrT  writeAddr,
  input  wire datapathPkg::dataWordT writeData,
  output datapathPkg::dataWordT      readDataA,
  output datapathPkg::dataWordT      readDataB
);

  datapathPkg::dataWordT regs [`REG_COUNT];

  // Reads see the old value during a write cycle
  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeAddr] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module executeCoreTb \
  -f filelist.f -o executeCoreSim

./obj_dir/executeCoreSim | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi
